/* Bender.yml */
package:
  name: tagged_fifo_shared

sources:
  - common/tagfifo_pkg.sv
  - shared_buffer/chan_tracker.sv
  - shared_buffer/shared_ram_1rw.sv
  - shared_buffer/shared_buffer.sv
  - hw/rr_arbiter.sv
  - hw/little_fifo_bank.sv
  - hw/tagged_fifo_shared_top.sv
  - target: simulation
    files:
      - tb/tb_tagged_fifo_shared.sv

/* common/tagfifo_pkg.sv */
// shared widths and beat types for the tagged demultiplexing FIFO
package tagfifo_pkg;

   // width of one data word
   localparam int data_width = 16;

   // number of output channels, buffered and unbuffered together
   localparam int num_chan = 4;

   // channel tag width, ceiling of log2 of the channel count
   localparam int tag_width = $clog2(num_chan);

   // a channel tag
   typedef logic [tag_width-1:0] tag_t;

   // a data word
   typedef logic [data_width-1:0] data_t;

   // one word of the input stream together with its destination channel
   typedef struct packed {
      tag_t  tag;
      data_t data;
   } in_beat_t;

   // registered result of a big RAM read on its way to the little FIFOs
   // valid marks a read that was actually issued the cycle before
   typedef struct packed {
      logic  valid;
      tag_t  tag;
      data_t data;
   } rd_beat_t;

   // one bit per channel, used for valid, acknowledge, request and credit vectors
   typedef logic [num_chan-1:0] chan_vec_t;

   // one data word per channel on the output side
   typedef data_t [num_chan-1:0] chan_data_t;

endpackage

/* hw/little_fifo_bank.sv */
`timescale 1ns/1ps

// small per-channel output FIFOs fed from the RAM read register
// unbuffered channels are wired straight from the input
module little_fifo_bank #(
   parameter int                     buffering       = 3,
   parameter tagfifo_pkg::chan_vec_t unbuffered_mask = '0
) (
   input  logic                       clk_i,
   input  logic                       rst_n_i,
   input  tagfifo_pkg::rd_beat_t      rd_beat_i,
   input  logic                       valid_i,
   input  tagfifo_pkg::in_beat_t      beat_i,
   input  tagfifo_pkg::chan_vec_t     yumi_i,
   output tagfifo_pkg::chan_vec_t     valid_o,
   output tagfifo_pkg::chan_data_t    data_o
);

   localparam int idx_width = $clog2(buffering);
   localparam int cnt_width = $clog2(buffering + 1);

   for (genvar i = 0; i < tagfifo_pkg::num_chan; i++)
   begin : g_chan
      if (unbuffered_mask[i])
      begin : g_unbuf
         // the consumer is assumed always ready here, so yumi_i is not looked at
         assign valid_o[i] = valid_i && (beat_i.tag == tagfifo_pkg::tag_width'(i));
         assign data_o[i]  = beat_i.data;
      end
      else
      begin : g_buf
         tagfifo_pkg::data_t   mem [buffering];
         logic [idx_width-1:0] wr_q;
         logic [idx_width-1:0] rd_q;
         logic [cnt_width-1:0] count_q;
         logic                 push;
         logic                 pop;

         assign push = rd_beat_i.valid && (rd_beat_i.tag == tagfifo_pkg::tag_width'(i));
         assign pop  = yumi_i[i];

         // payload slots carry no reset
         always_ff @(posedge clk_i)
         begin
            if (push)
               mem[wr_q] <= rd_beat_i.data;
         end

         // depth need not be a power of two, so both indices wrap explicitly
         always_ff @(posedge clk_i)
         begin
            if (!rst_n_i)
            begin
               wr_q    <= '0;
               rd_q    <= '0;
               count_q <= '0;
            end
            else
            begin
               if (push)
                  wr_q <= (wr_q == idx_width'(buffering - 1)) ? '0 : wr_q + 1'b1;
               if (pop)
                  rd_q <= (rd_q == idx_width'(buffering - 1)) ? '0 : rd_q + 1'b1;
               if (push && !pop)
                  count_q <= count_q + 1'b1;
               else if (pop && !push)
                  count_q <= count_q - 1'b1;
            end
         end

         assign valid_o[i] = (count_q != '0);
         assign data_o[i]  = mem[rd_q];

         // credits upstream reserve a slot before every read, so a full FIFO is never pushed
         a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            !(push && count_q == cnt_width'(buffering)));
      end
   end

endmodule

/* hw/rr_arbiter.sv */
`timescale 1ns/1ps

// round-robin choice of the channel that gets the next RAM read
module rr_arbiter (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  tagfifo_pkg::chan_vec_t req_i,
   output logic                   grant_valid_o,
   output tagfifo_pkg::tag_t      grant_tag_o,
   input  logic                   accept_i
);

   // channel that last had its grant accepted
   tagfifo_pkg::tag_t last_q;
   tagfifo_pkg::tag_t idx;

   // scan starts just after the last winner and wraps around once
   always_comb
   begin
      grant_valid_o = 1'b0;
      grant_tag_o   = last_q;
      idx           = last_q;
      for (int k = 1; k <= tagfifo_pkg::num_chan; k++)
      begin
         idx = tagfifo_pkg::tag_width'((int'(last_q) + k) % tagfifo_pkg::num_chan);
         if (!grant_valid_o && req_i[idx])
         begin
            grant_valid_o = 1'b1;
            grant_tag_o   = idx;
         end
      end
   end

   // a grant that is not taken does not cost the channel its turn
   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
         last_q <= tagfifo_pkg::tag_width'(tagfifo_pkg::num_chan - 1);
      else if (accept_i)
         last_q <= grant_tag_o;
   end

   // the RAM read may only be issued against a live grant
   a_accept_granted: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      accept_i |-> grant_valid_o);

endmodule

/* hw/tagged_fifo_shared_top.sv */
`timescale 1ns/1ps

// one-to-many tagged FIFO over a shared single-port RAM
module tagged_fifo_shared_top #(
   parameter int                     els_per_chan    = 8,
   parameter int                     buffering       = 3,
   parameter tagfifo_pkg::chan_vec_t unbuffered_mask = 4'b1000
) (
   input  logic                    clk_i,
   input  logic                    rst_n_i,
   input  logic                    valid_i,
   input  tagfifo_pkg::in_beat_t   beat_i,
   output logic                    yumi_o,
   output tagfifo_pkg::chan_vec_t  valid_o,
   input  tagfifo_pkg::chan_vec_t  yumi_i,
   output tagfifo_pkg::chan_data_t data_o
);

   tagfifo_pkg::chan_vec_t req;
   logic                   grant_valid;
   tagfifo_pkg::tag_t      grant_tag;
   logic                   grant_accept;
   tagfifo_pkg::rd_beat_t  rd_beat;

   shared_buffer #(
      .els_per_chan    (els_per_chan),
      .buffering       (buffering),
      .unbuffered_mask (unbuffered_mask)
   ) i_shared_buffer (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .valid_i        (valid_i),
      .beat_i         (beat_i),
      .yumi_o         (yumi_o),
      .chan_yumi_i    (yumi_i),
      .req_o          (req),
      .grant_valid_i  (grant_valid),
      .grant_tag_i    (grant_tag),
      .grant_accept_o (grant_accept),
      .rd_beat_o      (rd_beat)
   );

   rr_arbiter i_rr_arbiter (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .req_i         (req),
      .grant_valid_o (grant_valid),
      .grant_tag_o   (grant_tag),
      .accept_i      (grant_accept)
   );

   little_fifo_bank #(
      .buffering       (buffering),
      .unbuffered_mask (unbuffered_mask)
   ) i_little_fifo_bank (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .rd_beat_i (rd_beat),
      .valid_i   (valid_i),
      .beat_i    (beat_i),
      .yumi_i    (yumi_i),
      .valid_o   (valid_o),
      .data_o    (data_o)
   );

endmodule

/* project.f */
common/tagfifo_pkg.sv
shared_buffer/chan_tracker.sv
shared_buffer/shared_ram_1rw.sv
shared_buffer/shared_buffer.sv
hw/rr_arbiter.sv
hw/little_fifo_bank.sv
hw/tagged_fifo_shared_top.sv
tb/tb_tagged_fifo_shared.sv

/* shared_buffer/chan_tracker.sv */
`timescale 1ns/1ps

// pointer bookkeeping for one channel region of the shared RAM
module chan_tracker #(
   parameter int els_per_chan = 8,
   localparam int ptr_width = $clog2(els_per_chan)
) (
   input  logic                 clk_i,
   input  logic                 rst_n_i,
   input  logic                 enq_i,
   input  logic                 deq_i,
   output logic [ptr_width-1:0] wptr_o,
   output logic [ptr_width-1:0] rptr_o,
   output logic                 full_o,
   output logic                 empty_o
);

   // the top bit of each pointer is a wrap flag
   // equal flags with equal offsets mean empty, different flags mean full
   logic [ptr_width:0] wptr_q;
   logic [ptr_width:0] rptr_q;

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         wptr_q <= '0;
         rptr_q <= '0;
      end
      else
      begin
         // els_per_chan is a power of two so plain increments wrap the offset
         if (enq_i)
            wptr_q <= wptr_q + 1'b1;
         if (deq_i)
            rptr_q <= rptr_q + 1'b1;
      end
   end

   assign wptr_o  = wptr_q[ptr_width-1:0];
   assign rptr_o  = rptr_q[ptr_width-1:0];
   assign empty_o = (wptr_q == rptr_q);
   assign full_o  = (wptr_q[ptr_width] != rptr_q[ptr_width])
                 && (wptr_q[ptr_width-1:0] == rptr_q[ptr_width-1:0]);

   // admission upstream must stop at full, or the oldest word is overwritten
   a_no_enq_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(enq_i && full_o));

   // the arbiter may only grant a channel that holds data
   a_no_deq_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(deq_i && empty_o));

endmodule

/* shared_buffer/shared_buffer.sv */
`timescale 1ns/1ps

// input admission, per-channel trackers and credits, and the shared RAM port
module shared_buffer #(
   parameter int                     els_per_chan    = 8,
   parameter int                     buffering       = 3,
   parameter tagfifo_pkg::chan_vec_t unbuffered_mask = '0
) (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  logic                   valid_i,
   input  tagfifo_pkg::in_beat_t  beat_i,
   output logic                   yumi_o,
   input  tagfifo_pkg::chan_vec_t chan_yumi_i,
   output tagfifo_pkg::chan_vec_t req_o,
   input  logic                   grant_valid_i,
   input  tagfifo_pkg::tag_t      grant_tag_i,
   output logic                   grant_accept_o,
   output tagfifo_pkg::rd_beat_t  rd_beat_o
);

   localparam int ptr_width  = $clog2(els_per_chan);
   localparam int addr_width = tagfifo_pkg::tag_width + ptr_width;
   localparam int depth      = tagfifo_pkg::num_chan * els_per_chan;
   localparam int cred_width = $clog2(buffering + 1);

   logic [ptr_width-1:0]   wptr [tagfifo_pkg::num_chan];
   logic [ptr_width-1:0]   rptr [tagfifo_pkg::num_chan];
   tagfifo_pkg::chan_vec_t full;
   tagfifo_pkg::chan_vec_t empty;
   tagfifo_pkg::chan_vec_t enq;
   tagfifo_pkg::chan_vec_t deq;
   tagfifo_pkg::chan_vec_t in_onehot;
   tagfifo_pkg::chan_vec_t grant_onehot;

   logic                   tag_unbuf;
   logic                   ram_we;
   logic                   ram_re;
   logic [addr_width-1:0]  ram_addr;
   tagfifo_pkg::data_t     ram_rdata;
   logic                   rd_valid_q;
   tagfifo_pkg::tag_t      rd_tag_q;

   assign tag_unbuf    = unbuffered_mask[beat_i.tag];
   assign in_onehot    = tagfifo_pkg::chan_vec_t'(1) << beat_i.tag;
   assign grant_onehot = tagfifo_pkg::chan_vec_t'(1) << grant_tag_i;

   // unbuffered tags are always taken, buffered ones only while their region has room
   assign yumi_o = valid_i && (tag_unbuf || !full[beat_i.tag]);

   // only accepted buffered words are written, so a full region is never overwritten
   assign ram_we = yumi_o && !tag_unbuf;

   // the single port goes to the input whenever a word is offered
   // reads only use the idle cycles
   assign ram_re         = grant_valid_i && !valid_i;
   assign grant_accept_o = ram_re;

   assign enq = in_onehot & ~unbuffered_mask & {tagfifo_pkg::num_chan{ram_we}};
   assign deq = grant_onehot & {tagfifo_pkg::num_chan{ram_re}};

   // each region sits at the tag in the upper address bits
   assign ram_addr = ram_we ? {beat_i.tag, wptr[beat_i.tag]}
                            : {grant_tag_i, rptr[grant_tag_i]};

   for (genvar i = 0; i < tagfifo_pkg::num_chan; i++)
   begin : g_chan
      if (unbuffered_mask[i])
      begin : g_unbuf
         // nothing is ever stored for this channel, so it never asks for a read
         assign wptr[i]  = '0;
         assign rptr[i]  = '0;
         assign full[i]  = 1'b0;
         assign empty[i] = 1'b1;
         assign req_o[i] = 1'b0;
      end
      else
      begin : g_buf
         logic [cred_width-1:0] credit_q;

         chan_tracker #(
            .els_per_chan (els_per_chan)
         ) i_chan_tracker (
            .clk_i   (clk_i),
            .rst_n_i (rst_n_i),
            .enq_i   (enq[i]),
            .deq_i   (deq[i]),
            .wptr_o  (wptr[i]),
            .rptr_o  (rptr[i]),
            .full_o  (full[i]),
            .empty_o (empty[i])
         );

         // free slots in this channel's little FIFO, counting reads still in flight
         always_ff @(posedge clk_i)
         begin
            if (!rst_n_i)
               credit_q <= cred_width'(buffering);
            else if (deq[i] && !chan_yumi_i[i])
               credit_q <= credit_q - 1'b1;
            else if (chan_yumi_i[i] && !deq[i])
               credit_q <= credit_q + 1'b1;
         end

         assign req_o[i] = (credit_q != '0) && !empty[i];

         // a credit comes back only for a word that was read, so the count stays bounded
         a_credit_max: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            credit_q <= cred_width'(buffering));
      end
   end

   shared_ram_1rw #(
      .depth (depth)
   ) i_shared_ram_1rw (
      .clk_i   (clk_i),
      .en_i    (ram_we || ram_re),
      .we_i    (ram_we),
      .addr_i  (ram_addr),
      .wdata_i (beat_i.data),
      .rdata_o (ram_rdata)
   );

   // read tag travels alongside the RAM latency
   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         rd_valid_q <= 1'b0;
         rd_tag_q   <= '0;
      end
      else
      begin
         rd_valid_q <= ram_re;
         rd_tag_q   <= grant_tag_i;
      end
   end

   assign rd_beat_o.valid = rd_valid_q;
   assign rd_beat_o.tag   = rd_tag_q;
   assign rd_beat_o.data  = ram_rdata;

   // the arbiter must only hand out a channel from the current request vector
   a_grant_requested: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      grant_valid_i |-> req_o[grant_tag_i]);

endmodule

/* shared_buffer/shared_ram_1rw.sv */
`timescale 1ns/1ps

// single-port synchronous RAM that holds every channel region
module shared_ram_1rw #(
   parameter int depth = 32,
   localparam int addr_width = $clog2(depth)
) (
   input  logic                    clk_i,
   input  logic                    en_i,
   input  logic                    we_i,
   input  logic [addr_width-1:0]   addr_i,
   input  tagfifo_pkg::data_t      wdata_i,
   output tagfifo_pkg::data_t      rdata_o
);

   tagfifo_pkg::data_t mem [depth];

   // one access per cycle, a read lands in rdata_o at the clock edge
   // rdata_o keeps its value across writes and idle cycles
   always_ff @(posedge clk_i)
   begin
      if (en_i)
      begin
         if (we_i)
            mem[addr_i] <= wdata_i;
         else
            rdata_o <= mem[addr_i];
      end
   end

endmodule

/* tb/tb_tagged_fifo_shared.sv */
`timescale 1ns/1ps

module tb_tagged_fifo_shared;

   localparam int                     els_per_chan  = 8;
   localparam int                     buffering     = 3;
   localparam tagfifo_pkg::chan_vec_t unbuf_mask    = 4'b1000;
   localparam int                     clk_period    = 10;
   localparam int                     rand_cycles   = 600;
   localparam int                     drain_budget  = 120;
   localparam int                     settle_cycles = 40;
   localparam int                     rounds_one    = 15;
   localparam int                     rounds_all    = 42;
   localparam int                     blocked_offer = 6;
   // reset, random phase, five drains, two single-channel fills and the all-channel fill
   localparam int stim_cycles = 5 + rand_cycles + 5 * drain_budget
                              + 2 * (2 * rounds_one + settle_cycles + blocked_offer) + 2
                              + 2 * rounds_all + settle_cycles;
   localparam int watchdog_ns = stim_cycles * 4 * clk_period + 1000;

   logic                    clk_i;
   logic                    rst_n_i;
   logic                    valid_i;
   tagfifo_pkg::in_beat_t   beat_i;
   logic                    yumi_o;
   tagfifo_pkg::chan_vec_t  valid_o;
   tagfifo_pkg::chan_vec_t  yumi_i;
   tagfifo_pkg::chan_data_t data_o;

   // expected words per channel in arrival order
   tagfifo_pkg::data_t exp_q [tagfifo_pkg::num_chan][$];
   int unsigned        accept_cnt [tagfifo_pkg::num_chan];
   int unsigned        pop_cnt [tagfifo_pkg::num_chan];

   tagged_fifo_shared_top #(
      .els_per_chan    (els_per_chan),
      .buffering       (buffering),
      .unbuffered_mask (unbuf_mask)
   ) i_tagged_fifo_shared_top (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .valid_i (valid_i),
      .beat_i  (beat_i),
      .yumi_o  (yumi_o),
      .valid_o (valid_o),
      .yumi_i  (yumi_i),
      .data_o  (data_o)
   );

   always #(clk_period / 2) clk_i = ~clk_i;

   task automatic stop_failed();
      $display("Test FAILED");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic report_error(input string what);
      $display("Error at %0t: %s", $time, what);
      stop_failed();
   endtask

   task automatic check_data(input string what, input tagfifo_pkg::data_t got,
                             input tagfifo_pkg::data_t exp);
      if (got !== exp)
      begin
         $display("Mismatch at %0t: %s, got %h expected %h", $time, what, got, exp);
         stop_failed();
      end
   endtask

   task automatic check_count(input string what, input int unsigned got,
                              input int unsigned exp);
      if (got != exp)
      begin
         $display("Mismatch at %0t: %s, got %0d expected %0d", $time, what, got, exp);
         stop_failed();
      end
   endtask

   task automatic check_flag(input string what, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("Mismatch at %0t: %s, got %b expected %b", $time, what, got, exp);
         stop_failed();
      end
   endtask

   task automatic check_vec(input string what, input tagfifo_pkg::chan_vec_t got,
                            input tagfifo_pkg::chan_vec_t exp);
      if (got !== exp)
      begin
         $display("Mismatch at %0t: %s, got %b expected %b", $time, what, got, exp);
         stop_failed();
      end
   endtask

   // an accepted word is queued for its channel unless that channel bypasses storage
   function automatic bit model_accept(input tagfifo_pkg::in_beat_t beat);
      bit unbuf;
      unbuf = unbuf_mask[beat.tag];
      if (!unbuf)
         exp_q[beat.tag].push_back(beat.data);
      return unbuf;
   endfunction

   function automatic int unsigned pending_words();
      int unsigned total;
      total = 0;
      for (int i = 0; i < tagfifo_pkg::num_chan; i++)
         total += exp_q[i].size();
      return total;
   endfunction

   // one cycle of stimulus, acknowledges only go to channels that show a word
   task automatic drive_cycle(input logic valid, input tagfifo_pkg::tag_t tag,
                              input tagfifo_pkg::chan_vec_t ready);
      @(negedge clk_i);
      valid_i     = valid;
      beat_i.tag  = tag;
      beat_i.data = valid ? tagfifo_pkg::data_t'($urandom) : '0;
      yumi_i      = ready & valid_o & ~unbuf_mask;
   endtask

   task automatic clear_counts();
      for (int i = 0; i < tagfifo_pkg::num_chan; i++)
      begin
         accept_cnt[i] = 0;
         pop_cnt[i]    = 0;
      end
   endtask

   // offers go to the selected channels in turn on alternate cycles, so the
   // idle cycles between them let the arbiter move words into the little FIFOs
   task automatic fill_stalled(input tagfifo_pkg::chan_vec_t chans, input int rounds);
      tagfifo_pkg::tag_t t;
      t = '0;
      for (int k = 0; k < rounds; k++)
      begin
         while (!chans[t])
            t = t + 1'b1;
         drive_cycle(1'b1, t, '0);
         drive_cycle(1'b0, '0, '0);
         t = t + 1'b1;
      end
      repeat (settle_cycles) drive_cycle(1'b0, '0, '0);
   endtask

   // offer a word and look at the combinational acknowledge before the edge
   task automatic offer_and_check(input tagfifo_pkg::tag_t tag, input logic exp_yumi);
      drive_cycle(1'b1, tag, '0);
      @(posedge clk_i);
      check_flag($sformatf("yumi_o for tag %0d", tag), yumi_o, exp_yumi);
   endtask

   // release every output until the model holds nothing more or the budget runs out
   task automatic drain_all();
      int unsigned waited;
      waited = 0;
      while (pending_words() != 0 && waited < drain_budget)
      begin
         drive_cycle(1'b0, '0, '1);
         waited++;
      end
      check_count("words left in the model after the drain", pending_words(), 0);
      drive_cycle(1'b0, '0, '0);
      @(posedge clk_i);
      check_vec("valid_o after drain", valid_o & ~unbuf_mask, '0);
   endtask

   // accepts feed the model, and each output handshake pops and compares
   always @(posedge clk_i)
   begin : monitor
      tagfifo_pkg::data_t expected;
      if (rst_n_i)
      begin
         if (valid_i && unbuf_mask[beat_i.tag])
            check_flag("yumi_o on an unbuffered tag", yumi_o, 1'b1);
         if (valid_i && yumi_o)
         begin
            accept_cnt[beat_i.tag]++;
            if (model_accept(beat_i))
            begin
               check_flag("valid_o on the unbuffered channel", valid_o[beat_i.tag], 1'b1);
               check_data("data_o on the unbuffered channel", data_o[beat_i.tag],
                          beat_i.data);
            end
         end
         for (int i = 0; i < tagfifo_pkg::num_chan; i++)
         begin
            if (!unbuf_mask[i] && valid_o[i] && yumi_i[i])
            begin
               if (exp_q[i].size() == 0)
                  report_error($sformatf("channel %0d delivered a word never sent", i));
               expected = exp_q[i].pop_front();
               pop_cnt[i]++;
               check_data($sformatf("data_o on channel %0d", i), data_o[i], expected);
            end
         end
      end
   end

   initial
   begin : watchdog
      #(watchdog_ns);
      $display("Watchdog expired after %0d ns, the run appears to hang", watchdog_ns);
      stop_failed();
   end

   initial
   begin : stimulus
      void'($urandom(44));
      clk_i   = 1'b0;
      rst_n_i = 1'b0;
      valid_i = 1'b0;
      beat_i  = '0;
      yumi_i  = '0;
      clear_counts();
      repeat (3) @(posedge clk_i);
      @(negedge clk_i);
      rst_n_i = 1'b1;
      @(posedge clk_i);
      check_vec("valid_o after reset", valid_o, '0);
      check_flag("yumi_o after reset", yumi_o, 1'b0);

      // random traffic on every tag with random acknowledges
      for (int k = 0; k < rand_cycles; k++)
         drive_cycle(1'($urandom % 2), tagfifo_pkg::tag_t'($urandom),
                     tagfifo_pkg::chan_vec_t'($urandom));
      drain_all();

      // capacity of channel 0 is its region plus its little FIFO
      clear_counts();
      fill_stalled(4'b0001, rounds_one);
      check_count("words accepted on channel 0", accept_cnt[0], els_per_chan + buffering);
      repeat (blocked_offer) offer_and_check(2'd0, 1'b0);
      drain_all();

      // a full channel 1 blocks the stream, channel 2 gets through after the drain
      clear_counts();
      fill_stalled(4'b0010, rounds_one);
      repeat (blocked_offer) offer_and_check(2'd1, 1'b0);
      drain_all();
      offer_and_check(2'd1, 1'b1);
      offer_and_check(2'd2, 1'b1);
      drain_all();
      check_count("words drained on channel 1", pop_cnt[1], els_per_chan + buffering + 1);

      // fill all buffered channels, then release them together
      clear_counts();
      fill_stalled(~unbuf_mask, rounds_all);
      for (int i = 0; i < tagfifo_pkg::num_chan; i++)
      begin
         if (!unbuf_mask[i])
            check_count($sformatf("words accepted on channel %0d", i), accept_cnt[i],
                        els_per_chan + buffering);
      end
      drain_all();

      $display("Test OK");
      $finish;
   end

endmodule
